// ==== verilog/lsu_macros.svh ====
////////////////////////////////////////
// Widths and limits shared by the load/store unit
// Include before any package or module that sizes signals
////////////////////////////////////////

`default_nettype none

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Data and address width
`define LSU_XLEN 32
// One enable per byte lane
`define LSU_BE_W 4
// Bus transactions in flight at most
`define LSU_MAX_OUTSTANDING 2
// Wide enough to hold the outstanding limit
`define LSU_CNT_W 2

`endif

`default_nettype wire

// ==== verilog/obi_pkg.sv ====
////////////////////////////////////////
// Data bus types for the simplified OBI port
// Request bundle travels beside a separate req bit
////////////////////////////////////////

`include "lsu_macros.svh"

`default_nettype none

package obi_pkg;

  // Address phase payload, no valid bit inside
  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
    logic                 we;
    logic [`LSU_BE_W-1:0] be;
    logic [`LSU_XLEN-1:0] wdata;
  } obi_req_t;

  // Response phase payload, qualified by rvalid
  typedef struct packed {
    logic [`LSU_XLEN-1:0] rdata;
    logic                 err;
  } obi_resp_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_pkg.sv ====
////////////////////////////////////////
// Pipeline side types of the load/store unit
// Access size, split phase, request and writeback control
////////////////////////////////////////

`include "lsu_macros.svh"

`default_nettype none

package lsu_pkg;

  // Access size, encoded as in the core's funct3 low bits
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Which address phase of a split access is being issued
  typedef enum logic {
    PHASE_FIRST  = 1'b0,
    PHASE_SECOND = 1'b1
  } split_phase_e;

  // One load or store from the pipeline
  typedef struct packed {
    logic                 we;
    lsu_size_e            size;
    logic                 sign_ext;
    logic [`LSU_XLEN-1:0] base;
    logic [`LSU_XLEN-1:0] offset;
    logic [`LSU_XLEN-1:0] wdata;
  } lsu_req_t;

  // Control carried to the response side per address phase
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    logic      sign_ext;
    logic [1:0] addr_lsb;
    // Low on the first phase of a split access
    logic      last;
  } wb_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_decode.sv ====
////////////////////////////////////////
// Address and lane decode for one address phase
// Purely combinational, phase comes from execute
////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

`default_nettype none

module lsu_decode
  import obi_pkg::*;
  import lsu_pkg::*;
(
  input  lsu_req_t     req_i,
  input  split_phase_e phase_i,
  output obi_req_t     bus_o,
  output logic         split_o,
  output logic [1:0]   addr_lsb_o
);

  logic                 second;
  logic [`LSU_XLEN-1:0] addr;
  logic [`LSU_BE_W-1:0] be;
  logic [`LSU_XLEN-1:0] wdata_rot;

  assign second = (phase_i == PHASE_SECOND);

  // Base plus offset, next word for the second phase
  assign addr = req_i.base + req_i.offset + {{(`LSU_XLEN-3){1'b0}}, second, 2'b00};

  // Byte offset is the same in both phases
  assign addr_lsb_o = addr[1:0];

  // Word at nonzero offset or halfword at offset 3 crosses a word
  always_comb
  begin
    split_o = 1'b0;
    if (!second)
    begin
      if (req_i.size == LSU_WORD)
        split_o = (addr[1:0] != 2'b00);
      else if (req_i.size == LSU_HALF)
        split_o = (addr[1:0] == 2'b11);
    end
  end

  ////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////

  always_comb
  begin
    case (req_i.size)
      LSU_BYTE:
        be = 4'b0001 << addr[1:0];
      LSU_HALF:
      begin
        // Offset 3 upper byte goes to lane 0 of the next word
        if (second)
          be = 4'b0001;
        else if (addr[1:0] == 2'b11)
          be = 4'b1000;
        else
          be = 4'b0011 << addr[1:0];
      end
      default:
      begin
        // Remaining low lanes of the next word
        if (second)
          be = 4'b1111 >> (3'd4 - {1'b0, addr[1:0]});
        else
          be = 4'b1111 << addr[1:0];
      end
    endcase
  end

  // Rotate left by the byte offset, lanes wrap into the second word
  always_comb
  begin
    case (addr[1:0])
      2'b00: wdata_rot = req_i.wdata;
      2'b01: wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10: wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  // Second phase address is word aligned
  assign bus_o.addr  = second ? {addr[`LSU_XLEN-1:2], 2'b00} : addr;
  assign bus_o.we    = req_i.we;
  assign bus_o.be    = be;
  assign bus_o.wdata = wdata_rot;

endmodule

`default_nettype wire

// ==== verilog/lsu_execute.sv ====
////////////////////////////////////////
// Issue side of the load/store unit
// Counts outstanding transactions, tracks split phase and
// hands control to the response side in lock step
////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

`default_nettype none

module lsu_execute
  import obi_pkg::*;
  import lsu_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         req_valid_i,
  input  obi_req_t     bus_i,
  input  logic         split_i,
  input  logic [1:0]   addr_lsb_i,
  input  lsu_req_t     req_i,
  input  logic         obi_gnt_i,
  input  logic         obi_rvalid_i,
  output logic         req_ready_o,
  output logic         obi_req_o,
  output obi_req_t     obi_addr_o,
  output split_phase_e phase_o,
  output wb_ctrl_t     wb_ctrl_o,
  output logic         busy_o
);

  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  trans_valid;
  logic                  trans_fire;
  // Address phase complete and response side free
  logic                  done;
  split_phase_e          phase_q;
  wb_ctrl_t              wb_ctrl_q;

  // Issue only below the depth limit
  assign trans_valid = req_valid_i && (cnt_q < `LSU_MAX_OUTSTANDING);
  assign trans_fire  = trans_valid && obi_gnt_i;

  assign obi_req_o  = trans_valid;
  assign obi_addr_o = bus_i;

  ////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////

  always_comb
  begin
    case ({trans_fire, obi_rvalid_i})
      2'b10: cnt_d = cnt_q + 1'b1;
      2'b01: cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  // Nothing in flight, the grant alone completes the phase
  // One in flight, wait for its response in the same cycle
  // Full, our phase was already granted and waits for the older rvalid
  always_comb
  begin
    if (cnt_q == 0)
      done = trans_fire;
    else if (cnt_q == 1)
      done = trans_fire && obi_rvalid_i;
    else
      done = req_valid_i && obi_rvalid_i;
  end

  // Hold the pipeline across the first phase of a split
  assign req_ready_o = done && !split_i;

  ////////////////////////////////////////
  // Split phase and writeback control
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      phase_q <= PHASE_FIRST;
    else if (done)
      phase_q <= split_i ? PHASE_SECOND : PHASE_FIRST;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ctrl_q <= '0;
    end
    else if (done)
    begin
      wb_ctrl_q.we       <= req_i.we;
      wb_ctrl_q.size     <= req_i.size;
      wb_ctrl_q.sign_ext <= req_i.sign_ext;
      wb_ctrl_q.addr_lsb <= addr_lsb_i;
      wb_ctrl_q.last     <= !split_i;
    end
  end

  assign phase_o   = phase_q;
  assign wb_ctrl_o = wb_ctrl_q;
  assign busy_o    = (cnt_q != '0) || req_valid_i;

endmodule

`default_nettype wire

// ==== verilog/lsu_result.sv ====
////////////////////////////////////////
// Response side of the load/store unit
// Aligns and extends load data, merges split halves and errors
////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

`default_nettype none

module lsu_result
  import obi_pkg::*;
  import lsu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rvalid_i,
  input  obi_resp_t            rsp_i,
  input  wb_ctrl_t             wb_ctrl_i,
  output logic                 rsp_valid_o,
  output logic [`LSU_XLEN-1:0] rsp_rdata_o,
  output logic                 rsp_err_o
);

  logic [`LSU_XLEN-1:0]   rdata_q;
  logic                   err_q;
  logic                   split_wb;
  logic [2*`LSU_XLEN-1:0] window;
  logic [2*`LSU_XLEN-1:0] shifted;
  logic [`LSU_XLEN-1:0]   aligned;
  logic [`LSU_XLEN-1:0]   rdata_ext;

  // First half of a split load
  always_ff @(posedge clk)
  begin
    if (rvalid_i && !wb_ctrl_i.last && !wb_ctrl_i.we)
      rdata_q <= rsp_i.rdata;
  end

  // Same split rule as decode, seen from the last phase
  assign split_wb = ((wb_ctrl_i.size == LSU_WORD) && (wb_ctrl_i.addr_lsb != 2'b00)) ||
                    ((wb_ctrl_i.size == LSU_HALF) && (wb_ctrl_i.addr_lsb == 2'b11));

  // Saved word sits below the new one for split data
  assign window  = split_wb ? {rsp_i.rdata, rdata_q} : {{`LSU_XLEN{1'b0}}, rsp_i.rdata};
  assign shifted = window >> {wb_ctrl_i.addr_lsb, 3'b000};
  assign aligned = shifted[`LSU_XLEN-1:0];

  ////////////////////////////////////////
  // Zero or sign extension
  ////////////////////////////////////////

  always_comb
  begin
    case (wb_ctrl_i.size)
      LSU_BYTE:
        rdata_ext = {{(`LSU_XLEN-8){wb_ctrl_i.sign_ext & aligned[7]}}, aligned[7:0]};
      LSU_HALF:
        rdata_ext = {{(`LSU_XLEN-16){wb_ctrl_i.sign_ext & aligned[15]}}, aligned[15:0]};
      default:
        rdata_ext = aligned;
    endcase
  end

  // Sticky over the first phase, cleared by the last response
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      err_q <= 1'b0;
    else if (rvalid_i)
      err_q <= wb_ctrl_i.last ? 1'b0 : (err_q | rsp_i.err);
  end

  // One pulse per instruction
  assign rsp_valid_o = rvalid_i && wb_ctrl_i.last;
  assign rsp_rdata_o = rdata_ext;
  assign rsp_err_o   = rsp_valid_o && (err_q || rsp_i.err);

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
////////////////////////////////////////
// Load/store unit top level
// Pipeline request in, OBI data port out, one result per op
////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

`default_nettype none

module lsu_top
  import obi_pkg::*;
  import lsu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // Pipeline request
  input  logic                 req_valid_i,
  input  lsu_req_t             req_i,
  output logic                 req_ready_o,
  // OBI data port
  output logic                 obi_req_o,
  output obi_req_t             obi_addr_o,
  input  logic                 obi_gnt_i,
  input  logic                 obi_rvalid_i,
  input  obi_resp_t            obi_rsp_i,
  // Result, always accepted
  output logic                 rsp_valid_o,
  output logic [`LSU_XLEN-1:0] rsp_rdata_o,
  output logic                 rsp_err_o,
  output logic                 busy_o
);

  obi_req_t     bus;
  logic         split;
  logic [1:0]   addr_lsb;
  split_phase_e phase;
  wb_ctrl_t     wb_ctrl;

  lsu_decode u_decode (
    .req_i      (req_i),
    .phase_i    (phase),
    .bus_o      (bus),
    .split_o    (split),
    .addr_lsb_o (addr_lsb)
  );

  lsu_execute u_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .bus_i        (bus),
    .split_i      (split),
    .addr_lsb_i   (addr_lsb),
    .req_i        (req_i),
    .obi_gnt_i    (obi_gnt_i),
    .obi_rvalid_i (obi_rvalid_i),
    .req_ready_o  (req_ready_o),
    .obi_req_o    (obi_req_o),
    .obi_addr_o   (obi_addr_o),
    .phase_o      (phase),
    .wb_ctrl_o    (wb_ctrl),
    .busy_o       (busy_o)
  );

  lsu_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .rvalid_i    (obi_rvalid_i),
    .rsp_i       (obi_rsp_i),
    .wb_ctrl_i   (wb_ctrl),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o)
  );

endmodule

`default_nettype wire

// ==== test/lsu_asserts.sv ====
////////////////////////////////////////
// OBI protocol assertions, bound into the top level
////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

`default_nettype none

module lsu_asserts
  import obi_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     req_valid_i,
  input logic     req_ready_o,
  input logic     obi_req_o,
  input obi_req_t obi_addr_o,
  input logic     obi_gnt_i,
  input logic     obi_rvalid_i,
  input logic     rsp_valid_o
);

  // Own count of transactions in flight, seen from the bus
  int outstanding;
  // Accepted instructions still waiting for their result
  int inst_pending;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(obi_req_o && obi_gnt_i) - int'(obi_rvalid_i);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      inst_pending <= 0;
    else
      inst_pending <= inst_pending + int'(req_valid_i && req_ready_o) - int'(rsp_valid_o);
  end

  // Address phase held until granted
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_addr_o))
    else $error("req or address changed before grant");

  a_depth: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= `LSU_MAX_OUTSTANDING)
    else $error("more than two transactions outstanding");

  a_rsp_owned: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |-> inst_pending != 0)
    else $error("result with no instruction outstanding");

endmodule

bind lsu_top lsu_asserts u_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .req_valid_i  (req_valid_i),
  .req_ready_o  (req_ready_o),
  .obi_req_o    (obi_req_o),
  .obi_addr_o   (obi_addr_o),
  .obi_gnt_i    (obi_gnt_i),
  .obi_rvalid_i (obi_rvalid_i),
  .rsp_valid_o  (rsp_valid_o)
);

`default_nettype wire

// ==== test/lsu_tb.sv ====
////////////////////////////////////////
// Testbench for the load/store unit
// Drives directed and random loads and stores through a
// randomly stalling OBI memory model, checks against a byte model
////////////////////////////////////////

`timescale 1ns/1ps
`include "lsu_macros.svh"

`default_nettype none

module lsu_tb
  import obi_pkg::*;
  import lsu_pkg::*;
();

  localparam int N_DIRECTED     = 46;
  localparam int N_RANDOM       = 200;
  localparam int NUM_OPS        = N_DIRECTED + N_RANDOM;
  localparam int TIMEOUT_CYCLES = 40 * NUM_OPS;
  // Word that answers every access with err
  localparam logic [5:0] ERR_WORD = 6'd40;

  typedef struct packed {
    logic        we;
    logic [31:0] rdata;
    logic        err;
  } exp_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic [31:0] due;
  } pend_t;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  logic                 req_valid_i = 1'b0;
  lsu_req_t             req_i = '0;
  logic                 req_ready_o;
  logic                 obi_req_o;
  obi_req_t             obi_addr_o;
  logic                 obi_gnt_i = 1'b0;
  logic                 obi_rvalid_i = 1'b0;
  obi_resp_t            obi_rsp_i = '0;
  logic                 rsp_valid_o;
  logic [`LSU_XLEN-1:0] rsp_rdata_o;
  logic                 rsp_err_o;
  logic                 busy_o;

  integer      seed = 32'hb3f05667;
  integer      bus_seed = 32'hb3f05667 ^ 32'h0000_0001;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [31:0] mem [0:63];
  logic [7:0]  ref_mem [0:255];
  exp_t        exp_q [$];
  pend_t       pend_q [$];

  lsu_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .obi_req_o    (obi_req_o),
    .obi_addr_o   (obi_addr_o),
    .obi_gnt_i    (obi_gnt_i),
    .obi_rvalid_i (obi_rvalid_i),
    .obi_rsp_i    (obi_rsp_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o),
    .busy_o       (busy_o)
  );

  always #10 clk = ~clk;

  task automatic note_fail(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  function automatic int size_bytes(input lsu_size_e size);
    if (size == LSU_BYTE)
      return 1;
    else if (size == LSU_HALF)
      return 2;
    return 4;
  endfunction

  // Lanes touched in the first word (low nibble) and the next word (high nibble)
  function automatic logic [7:0] lane_mask(input lsu_size_e size, input logic [1:0] lsb);
    logic [7:0] m;
    int i;
    m = '0;
    for (i = 0; i < size_bytes(size); i++)
      m[int'(lsb) + i] = 1'b1;
    return m;
  endfunction

  ////////////////////////////////////////
  // OBI memory model
  ////////////////////////////////////////

  always @(posedge clk)
  begin
    logic [31:0] a;
    logic [7:0]  m;
    logic [3:0]  exp_be;
    logic [31:0] exp_addr;
    logic [5:0]  w;
    pend_t       p;
    int          lane;
    int          grants;
    int          mcyc;
    int          in_flight;
    if (!rst_n)
    begin
      grants = 0;
      mcyc = 0;
      in_flight = 0;
      obi_gnt_i <= 1'b0;
      obi_rvalid_i <= 1'b0;
      obi_rsp_i <= '0;
    end
    else
    begin
      mcyc++;
      // Busy while the bus has work in flight or a request waits
      checks++;
      assert (busy_o == ((in_flight != 0) || req_valid_i))
      else
        note_fail($sformatf("busy %b with %0d in flight and req_valid %b", busy_o,
                            in_flight, req_valid_i));
      in_flight = in_flight + int'(obi_req_o && obi_gnt_i) - int'(obi_rvalid_i);
      a = req_i.base + req_i.offset;
      m = lane_mask(req_i.size, a[1:0]);
      if (obi_req_o && obi_gnt_i)
      begin
        // Phase checks against the current pipeline request
        exp_be = (grants == 0) ? m[3:0] : m[7:4];
        exp_addr = (grants == 0) ? a : ({a[31:2], 2'b00} + 32'd4);
        checks++;
        assert (obi_addr_o.be == exp_be && obi_addr_o.addr == exp_addr &&
                obi_addr_o.we == req_i.we)
        else
          note_fail($sformatf("grant %0d addr %h be %b, expected addr %h be %b", grants,
                              obi_addr_o.addr, obi_addr_o.be, exp_addr, exp_be));
        grants++;
        w = obi_addr_o.addr[7:2];
        if (obi_addr_o.we && w != ERR_WORD)
        begin
          for (lane = 0; lane < 4; lane++)
            if (obi_addr_o.be[lane])
              mem[w][8*lane +: 8] = obi_addr_o.wdata[8*lane +: 8];
        end
        p.rdata = mem[w];
        p.err = (w == ERR_WORD);
        p.due = mcyc + 1 + ($unsigned($random(bus_seed)) % 3);
        pend_q.push_back(p);
      end
      if (req_ready_o)
      begin
        checks++;
        assert (grants == ((m[7:4] != 4'b0000) ? 2 : 1))
        else
          note_fail($sformatf("%0d grants for access at %h", grants, a));
        grants = 0;
      end
      obi_gnt_i <= (($random(bus_seed) & 3) != 0);
      if (pend_q.size() > 0 && pend_q[0].due <= mcyc + 1)
      begin
        p = pend_q.pop_front();
        obi_rvalid_i <= 1'b1;
        obi_rsp_i <= {p.rdata, p.err};
      end
      else
      begin
        obi_rvalid_i <= 1'b0;
        obi_rsp_i <= '0;
      end
    end
  end

  // Result monitor, one pulse per instruction in order
  always @(posedge clk)
  begin
    exp_t e;
    if (rst_n && rsp_valid_o)
    begin
      if (exp_q.size() == 0)
        note_fail("result pulse with no instruction pending");
      else
      begin
        e = exp_q.pop_front();
        checks++;
        assert (rsp_err_o == e.err)
        else
          note_fail($sformatf("err %b expected %b", rsp_err_o, e.err));
        if (!e.we)
        begin
          checks++;
          assert (rsp_rdata_o == e.rdata)
          else
            note_fail($sformatf("rdata %h expected %h", rsp_rdata_o, e.rdata));
        end
      end
    end
  end

  // Watchdog
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, %0d results still pending", cycles, exp_q.size());
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Update the byte model, queue the expected result, hold until accepted
  task automatic issue(input logic we, input lsu_size_e size, input logic sx,
                       input logic [31:0] base, input logic [31:0] off,
                       input logic [31:0] wdata);
    lsu_req_t    r;
    exp_t        e;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [31:0] v;
    int          n;
    int          i;
    a = 8'(base + off);
    n = size_bytes(size);
    v = '0;
    e.err = 1'b0;
    for (i = 0; i < n; i++)
    begin
      b = a + 8'(i);
      if (b[7:2] == ERR_WORD)
        e.err = 1'b1;
      if (we && b[7:2] != ERR_WORD)
        ref_mem[b] = wdata[8*i +: 8];
      else
        v[8*i +: 8] = ref_mem[b];
    end
    if (n == 1)
      v = {{24{sx & v[7]}}, v[7:0]};
    else if (n == 2)
      v = {{16{sx & v[15]}}, v[15:0]};
    e.we = we;
    e.rdata = v;
    exp_q.push_back(e);
    r.we = we;
    r.size = size;
    r.sign_ext = sx;
    r.base = base;
    r.offset = off;
    r.wdata = wdata;
    req_i <= r;
    req_valid_i <= 1'b1;
    do
      @(posedge clk);
    while (!req_ready_o);
  endtask

  initial
  begin
    int i;
    int k;
    logic [31:0] exp_word;
    // Fill pattern mixes every address bit
    for (i = 0; i < 64; i++)
    begin
      mem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i * 3), 8'(i) + 8'hc3};
      for (k = 0; k < 4; k++)
        ref_mem[4*i + k] = mem[i][8*k +: 8];
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Aligned stores and loads
    issue(1'b1, LSU_WORD, 1'b0, 32'h10, 32'h0, 32'hdeadbeef);
    issue(1'b0, LSU_WORD, 1'b0, 32'h10, 32'h0, 32'h0);
    issue(1'b1, LSU_HALF, 1'b0, 32'h20, 32'h0, 32'h0000a55a);
    issue(1'b1, LSU_HALF, 1'b0, 32'h20, 32'h2, 32'h00001234);
    issue(1'b0, LSU_HALF, 1'b0, 32'h20, 32'h0, 32'h0);
    issue(1'b0, LSU_HALF, 1'b0, 32'h20, 32'h2, 32'h0);
    for (k = 0; k < 4; k++)
      issue(1'b1, LSU_BYTE, 1'b0, 32'h30, 32'(k), 32'h80 + 32'(k * 17));
    for (k = 0; k < 4; k++)
      issue(1'b0, LSU_BYTE, 1'b0, 32'h30, 32'(k), 32'h0);

    // Zero and sign extension at every offset, positive and negative lanes
    issue(1'b1, LSU_WORD, 1'b0, 32'h40, 32'h0, 32'h7f8e5da4);
    issue(1'b1, LSU_WORD, 1'b0, 32'h44, 32'h0, 32'h7f6e5d84);
    for (k = 0; k < 8; k++)
      issue(1'b0, LSU_BYTE, k[0], 32'h40, 32'(k / 2), 32'h0);
    for (k = 0; k < 8; k++)
      issue(1'b0, LSU_HALF, k[0], 32'h40, 32'(k / 2), 32'h0);

    // Misaligned words
    for (k = 1; k < 4; k++)
    begin
      issue(1'b1, LSU_WORD, 1'b0, 32'h50, 32'(k), 32'h11223344 * 32'(k));
      issue(1'b0, LSU_WORD, 1'b0, 32'h50, 32'(k), 32'h0);
    end

    // Halfword at offset 3 splits, offset 1 does not
    issue(1'b1, LSU_HALF, 1'b0, 32'h60, 32'h3, 32'h0000c3d2);
    issue(1'b0, LSU_HALF, 1'b1, 32'h60, 32'h3, 32'h0);
    issue(1'b0, LSU_HALF, 1'b1, 32'h60, 32'h1, 32'h0);

    // Error word hit on the first, second or only phase
    issue(1'b0, LSU_WORD, 1'b0, 32'h9c, 32'h2, 32'h0);
    issue(1'b0, LSU_WORD, 1'b0, 32'ha0, 32'h1, 32'h0);
    issue(1'b0, LSU_WORD, 1'b0, 32'ha0, 32'h0, 32'h0);
    issue(1'b0, LSU_HALF, 1'b0, 32'h9c, 32'h3, 32'h0);
    issue(1'b0, LSU_BYTE, 1'b0, 32'ha0, 32'h3, 32'h0);

    // Random back-to-back traffic
    for (k = 0; k < N_RANDOM; k++)
      issue($random(seed) & 1, lsu_size_e'(2'($unsigned($random(seed)) % 3)),
            $random(seed) & 1, 32'($random(seed) & 8'hff), 32'($random(seed) & 7),
            $random(seed));
    req_valid_i <= 1'b0;

    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (4) @(posedge clk);

    // Final memory image against the byte model
    for (i = 0; i < 64; i++)
    begin
      exp_word = {ref_mem[4*i + 3], ref_mem[4*i + 2], ref_mem[4*i + 1], ref_mem[4*i]};
      checks++;
      assert (mem[i] == exp_word)
      else
        note_fail($sformatf("mem word %0d is %h, expected %h", i, mem[i], exp_word));
    end

    $display("checks=%0d errors=%0d cycles=%0d", checks, errors, cycles);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/obi_pkg.sv
verilog/lsu_pkg.sv
verilog/lsu_decode.sv
verilog/lsu_execute.sv
verilog/lsu_result.sv
verilog/lsu_top.sv
test/lsu_asserts.sv
test/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module lsu_tb -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
